// ==== sim.f ====
+incdir+test
src/memIqPkg.sv
src/memIqDispatch.sv
src/memIqSlot.sv
src/memIqSelect.sv
src/memIssueQueue.sv
test/memIqTb.sv

// ==== src/memIqDispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module memIqDispatch (
    input  wire memIqPkg::dispatchLane_t dispatchIn [memIqPkg::DispatchWidth],
    input  wire memIqPkg::wakeupBus_t    wakeup [memIqPkg::WakeupPorts],
    input  wire logic [memIqPkg::IqDepth-1:0] slotBusy,
    input  wire logic                    flush,
    output memIqPkg::slotWrite_t         slotWrite [memIqPkg::IqDepth],
    output logic                         dispatchReady
);
    import memIqPkg::*;

    logic [SlotIdxW:0]   freeCnt;
    logic [SlotIdxW-1:0] pickIdx [DispatchWidth];
    logic                pickHit [DispatchWidth];
    memUop_t             laneUop [DispatchWidth];
    logic [IqDepth-1:0]  writeEn;

    always_comb begin
        freeCnt = '0;
        for (int s = 0; s < IqDepth; s++) begin
            freeCnt += {{SlotIdxW{1'b0}}, ~slotBusy[s]};
        end
    end

    assign dispatchReady = freeCnt >= DispatchWidth;

    // lane 0 gets the lowest free slot, lane 1 the next one up
    always_comb begin
        logic [IqDepth-1:0] avail;
        avail = ~slotBusy;
        for (int l = 0; l < DispatchWidth; l++) begin
            pickIdx[l] = '0;
            pickHit[l] = 1'b0;
            for (int s = IqDepth - 1; s >= 0; s--) begin
                if (avail[s]) begin
                    pickIdx[l] = SlotIdxW'(s);
                    pickHit[l] = 1'b1;
                end
            end
            if (pickHit[l]) begin
                avail[pickIdx[l]] = 1'b0;
            end
        end
    end

    // same-cycle broadcast catches operands on their way in
    always_comb begin
        for (int l = 0; l < DispatchWidth; l++) begin
            laneUop[l] = dispatchIn[l].uop;
            laneUop[l].src1.ready = !dispatchIn[l].uop.src1.used || dispatchIn[l].uop.src1.ready
                                    || tagWoken(dispatchIn[l].uop.src1.tag, wakeup);
            laneUop[l].src2.ready = !dispatchIn[l].uop.src2.used || dispatchIn[l].uop.src2.ready
                                    || tagWoken(dispatchIn[l].uop.src2.tag, wakeup);
        end
    end

    always_comb begin
        for (int s = 0; s < IqDepth; s++) begin
            slotWrite[s] = '0;
        end
        for (int l = 0; l < DispatchWidth; l++) begin
            if (dispatchIn[l].valid && dispatchReady && pickHit[l] && !flush) begin
                slotWrite[pickIdx[l]].en  = 1'b1;
                slotWrite[pickIdx[l]].uop = laneUop[l];
            end
        end
    end

    always_comb begin
        for (int s = 0; s < IqDepth; s++) begin
            writeEn[s] = slotWrite[s].en;
        end
    end

    // a held entry must never be overwritten
    always_comb begin
        if (!$isunknown(slotBusy)) begin
            assert final ((writeEn & slotBusy) == '0)
                else $error("dispatch write hits busy slot, en %b busy %b", writeEn, slotBusy);
        end
    end

endmodule

`default_nettype wire

// ==== src/memIqPkg.sv ====
`default_nettype none

package memIqPkg;

    localparam int IqDepth       = 8;
    localparam int SlotIdxW      = 3;
    localparam int DispatchWidth = 2;
    localparam int WakeupPorts   = 4;
    localparam int PhysTagW      = 7;
    localparam int RobPtrW       = 7;  // msb is the wrap bit
    localparam int ImmW          = 26;
    localparam int MicroOpW      = 8;

    typedef struct packed {
        logic                used;
        logic                ready;
        logic [PhysTagW-1:0] tag;
    } srcOperand_t;

    typedef struct packed {
        logic [MicroOpW-1:0] microOp;
        logic                isStore;
        logic                immUsed;
        logic [ImmW-1:0]     imm;
        logic                dstUsed;
        logic [PhysTagW-1:0] dstTag;
        srcOperand_t         src1;
        srcOperand_t         src2;
        logic [RobPtrW-1:0]  robPtr;
    } memUop_t;

    typedef struct packed {
        logic    valid;
        memUop_t uop;
    } dispatchLane_t;

    typedef struct packed {
        logic                valid;
        logic [PhysTagW-1:0] tag;
    } wakeupBus_t;

    typedef struct packed {
        logic    en;
        memUop_t uop;
    } slotWrite_t;

    typedef struct packed {
        logic               valid;
        logic               ready;
        logic               isStore;
        logic [RobPtrW-1:0] robPtr;
    } slotState_t;

    typedef struct packed {
        logic    valid;
        memUop_t uop;
    } issuePort_t;

    function automatic logic tagWoken(input logic [PhysTagW-1:0] tag,
                                      input wakeupBus_t wk [WakeupPorts]);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WakeupPorts; p++) begin
            hit |= wk[p].valid && (wk[p].tag == tag);
        end
        return hit;
    endfunction

    // true when a is older than b in rob order
    function automatic logic isOlder(input logic [RobPtrW-1:0] a, input logic [RobPtrW-1:0] b);
        if (a[RobPtrW-1] == b[RobPtrW-1]) begin
            return a[RobPtrW-2:0] < b[RobPtrW-2:0];
        end
        return a[RobPtrW-2:0] > b[RobPtrW-2:0];  // b has wrapped past a
    endfunction

endpackage

`default_nettype wire

// ==== src/memIqSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module memIqSelect (
    input  wire memIqPkg::slotState_t slotStates [memIqPkg::IqDepth],
    input  wire memIqPkg::memUop_t    slotUops [memIqPkg::IqDepth],
    input  wire logic                 loadReady,
    input  wire logic                 storeReady,
    input  wire logic                 stop,
    output memIqPkg::issuePort_t      loadIssue,
    output memIqPkg::issuePort_t      storeIssue,
    output logic [memIqPkg::IqDepth-1:0] issueGrant
);
    import memIqPkg::*;

    localparam int NodeCnt = 2 * IqDepth - 1;

    // tree per unit, 0 for loads and 1 for stores
    // node n has children 2n+1 and 2n+2, leaves sit at IqDepth-1 and up
    logic                nodeV   [2][NodeCnt];
    logic [SlotIdxW-1:0] nodeIdx [2][NodeCnt];
    logic [RobPtrW-1:0]  nodePtr [2][NodeCnt];
    logic                loadFire;
    logic                storeFire;

    always_comb begin
        logic takeRight;
        for (int u = 0; u < 2; u++) begin
            for (int s = 0; s < IqDepth; s++) begin
                nodeV[u][IqDepth-1+s]   = slotStates[s].valid && slotStates[s].ready
                                          && (slotStates[s].isStore == 1'(u));
                nodeIdx[u][IqDepth-1+s] = SlotIdxW'(s);
                nodePtr[u][IqDepth-1+s] = slotStates[s].robPtr;
            end
            for (int n = IqDepth - 2; n >= 0; n--) begin
                // right child wins only if left is empty or right is older
                takeRight = nodeV[u][2*n+2] && (!nodeV[u][2*n+1]
                            || isOlder(nodePtr[u][2*n+2], nodePtr[u][2*n+1]));
                nodeV[u][n]   = nodeV[u][2*n+1] || nodeV[u][2*n+2];
                nodeIdx[u][n] = takeRight ? nodeIdx[u][2*n+2] : nodeIdx[u][2*n+1];
                nodePtr[u][n] = takeRight ? nodePtr[u][2*n+2] : nodePtr[u][2*n+1];
            end
        end
    end

    assign loadFire  = nodeV[0][0] && loadReady && !stop;
    assign storeFire = nodeV[1][0] && storeReady && !stop;

    assign loadIssue  = '{valid: loadFire, uop: slotUops[nodeIdx[0][0]]};
    assign storeIssue = '{valid: storeFire, uop: slotUops[nodeIdx[1][0]]};

    always_comb begin
        issueGrant = '0;
        if (loadFire) begin
            issueGrant[nodeIdx[0][0]] = 1'b1;
        end
        if (storeFire) begin
            issueGrant[nodeIdx[1][0]] = 1'b1;
        end
    end

    // the two trees see disjoint leaves, so winners never collide
    always_comb begin
        if (loadFire && storeFire) begin
            assert final (nodeIdx[0][0] != nodeIdx[1][0])
                else $error("load and store both granted slot %0d", nodeIdx[0][0]);
        end
    end

endmodule

`default_nettype wire

// ==== src/memIqSlot.sv ====
`timescale 1ns/1ps
`default_nettype none

module memIqSlot (
    input  wire logic                 Clk,
    input  wire logic                 rstN,
    input  wire logic                 flush,
    input  wire memIqPkg::slotWrite_t write,
    input  wire memIqPkg::wakeupBus_t wakeup [memIqPkg::WakeupPorts],
    input  wire logic                 grant,
    output memIqPkg::slotState_t      state,
    output memIqPkg::memUop_t         uop,
    output logic                      busy
);
    import memIqPkg::*;

    memUop_t uopQ;
    logic    validQ;
    logic    src1Wake;
    logic    src2Wake;
    logic    srcReady;

    assign src1Wake = tagWoken(uopQ.src1.tag, wakeup);
    assign src2Wake = tagWoken(uopQ.src2.tag, wakeup);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (flush) begin
            validQ <= 1'b0;
        end else if (write.en) begin
            validQ <= 1'b1;
        end else if (grant) begin
            validQ <= 1'b0;  // taken by its unit this cycle
        end
    end

    always_ff @(posedge Clk) begin
        if (write.en) begin
            uopQ <= write.uop;
        end else begin
            if (src1Wake) begin
                uopQ.src1.ready <= 1'b1;
            end
            if (src2Wake) begin
                uopQ.src2.ready <= 1'b1;
            end
        end
    end

    // unused sources arrive already marked ready
    assign srcReady = uopQ.src1.ready && uopQ.src2.ready;

    assign state = '{valid: validQ, ready: validQ && srcReady,
                     isStore: uopQ.isStore, robPtr: uopQ.robPtr};
    assign uop   = uopQ;
    assign busy  = validQ;

    // select only grants slots that hold a ready entry
    assert property (@(posedge Clk) disable iff (!rstN) grant |-> validQ && srcReady)
        else $error("grant to empty or unready slot");

endmodule

`default_nettype wire

// ==== src/memIssueQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module memIssueQueue (
    input  wire logic                    Clk,
    input  wire logic                    rstN,
    input  wire logic                    flush,
    input  wire logic                    stop,
    input  wire memIqPkg::dispatchLane_t dispatchIn [memIqPkg::DispatchWidth],
    output logic                         dispatchReady,
    input  wire memIqPkg::wakeupBus_t    wakeup [memIqPkg::WakeupPorts],
    input  wire logic                    loadReady,
    output memIqPkg::issuePort_t         loadIssue,
    input  wire logic                    storeReady,
    output memIqPkg::issuePort_t         storeIssue
);
    import memIqPkg::*;

    slotWrite_t         slotWrite  [IqDepth];
    slotState_t         slotStates [IqDepth];
    memUop_t            slotUops   [IqDepth];
    logic [IqDepth-1:0] slotBusy;
    logic [IqDepth-1:0] issueGrant;

    memIqDispatch uDispatch (
        .dispatchIn    (dispatchIn),
        .wakeup        (wakeup),
        .slotBusy      (slotBusy),
        .flush         (flush),
        .slotWrite     (slotWrite),
        .dispatchReady (dispatchReady)
    );

    for (genvar i = 0; i < IqDepth; i++) begin : gSlot
        memIqSlot uSlot (
            .Clk    (Clk),
            .rstN   (rstN),
            .flush  (flush),
            .write  (slotWrite[i]),
            .wakeup (wakeup),
            .grant  (issueGrant[i]),
            .state  (slotStates[i]),
            .uop    (slotUops[i]),
            .busy   (slotBusy[i])
        );
    end

    memIqSelect uSelect (
        .slotStates (slotStates),
        .slotUops   (slotUops),
        .loadReady  (loadReady),
        .storeReady (storeReady),
        .stop       (stop),
        .loadIssue  (loadIssue),
        .storeIssue (storeIssue),
        .issueGrant (issueGrant)
    );

endmodule

`default_nettype wire

// ==== test/memIqTable.svh ====
// one row per cycle: testId, lane 0, lane 1, wakeup, ctl = {loadReady, storeReady, stop, flush}
// then expected dispatchReady, loadIssue and storeIssue (valid plus robPtr)
// basic issue
addRow(1, ld(7'h01), st(7'h02), noWake(), 4'b1100, 1, quiet(), quiet());
addRow(1, idle(), idle(), noWake(), 4'b1100, 1, issue(7'h01), issue(7'h02));
// wakeup, late broadcast then same-cycle broadcast
addRow(2, ldWait(7'h03, 7'h11), idle(), noWake(), 4'b1000, 1, quiet(), quiet());
addRow(2, idle(), idle(), noWake(), 4'b1000, 1, quiet(), quiet());
addRow(2, idle(), idle(), wake(2, 7'h11), 4'b1000, 1, quiet(), quiet());
addRow(2, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h03), quiet());
addRow(2, ldWait(7'h04, 7'h22), idle(), wake(1, 7'h22), 4'b1000, 1, quiet(), quiet());
addRow(2, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h04), quiet());
// oldest first across the wrap, 7e then 7f then 01
addRow(3, ld(7'h01), ld(7'h7f), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(3, ld(7'h7e), idle(), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(3, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h7e), quiet());
addRow(3, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h7f), quiet());
addRow(3, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h01), quiet());
addRow(3, idle(), idle(), noWake(), 4'b1000, 1, quiet(), quiet());
// back-pressure from loadReady and stop
addRow(4, ld(7'h10), st(7'h11), noWake(), 4'b0100, 1, quiet(), quiet());
addRow(4, idle(), idle(), noWake(), 4'b0110, 1, quiet(), quiet());
addRow(4, idle(), idle(), noWake(), 4'b0100, 1, quiet(), issue(7'h11));
addRow(4, ld(7'h0f), ldWait(7'h0e, 7'h44), noWake(), 4'b1010, 1, quiet(), quiet());
addRow(4, idle(), idle(), wake(3, 7'h44), 4'b1010, 1, quiet(), quiet());
addRow(4, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h0e), quiet());
addRow(4, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h0f), quiet());
addRow(4, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h10), quiet());
// full queue, 70 and 71 are offered while not ready
addRow(5, ld(7'h20), ld(7'h21), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(5, ld(7'h22), ld(7'h23), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(5, ld(7'h24), ld(7'h25), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(5, ld(7'h26), idle(), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(5, ld(7'h70), ld(7'h71), noWake(), 4'b0000, 0, quiet(), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 0, issue(7'h20), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h21), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h22), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h23), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h24), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h25), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, issue(7'h26), quiet());
addRow(5, idle(), idle(), noWake(), 4'b1000, 1, quiet(), quiet());
// flush with six held, both lanes offered in the flush cycle are dropped
addRow(6, ld(7'h30), st(7'h31), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(6, ld(7'h32), st(7'h33), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(6, ld(7'h34), st(7'h35), noWake(), 4'b0000, 1, quiet(), quiet());
addRow(6, ld(7'h36), st(7'h37), noWake(), 4'b0001, 1, quiet(), quiet());
addRow(6, idle(), idle(), noWake(), 4'b1100, 1, quiet(), quiet());
addRow(6, idle(), idle(), noWake(), 4'b1100, 1, quiet(), quiet());

// ==== test/memIqTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memIqTb;
    import memIqPkg::*;

    typedef struct packed {
        logic               valid;
        logic [RobPtrW-1:0] robPtr;
    } expIssue_t;

    typedef struct packed {
        logic                valid;
        logic [1:0]          port;
        logic [PhysTagW-1:0] tag;
    } wakeDrive_t;

    typedef struct packed {
        logic [2:0]    testId;
        dispatchLane_t lane0;
        dispatchLane_t lane1;
        wakeDrive_t    wk;
        logic [3:0]    ctl;  // loadReady, storeReady, stop, flush
        logic          expDr;
        expIssue_t     expLd;
        expIssue_t     expSt;
    } row_t;

    logic          Clk;
    logic          rstN;
    logic          flush;
    logic          stop;
    dispatchLane_t dispatchIn [DispatchWidth];
    logic          dispatchReady;
    wakeupBus_t    wakeup [WakeupPorts];
    logic          loadReady;
    issuePort_t    loadIssue;
    logic          storeReady;
    issuePort_t    storeIssue;

    row_t  rows [$];
    logic  tableReady = 1'b0;
    int    checks = 0;
    int    errors = 0;
    int    testStartErr = 0;
    string testNames [6] = '{"basic issue", "wakeup", "oldest first", "back-pressure",
                             "full queue", "flush"};

    memIssueQueue dut (
        .Clk           (Clk),
        .rstN          (rstN),
        .flush         (flush),
        .stop          (stop),
        .dispatchIn    (dispatchIn),
        .dispatchReady (dispatchReady),
        .wakeup        (wakeup),
        .loadReady     (loadReady),
        .loadIssue     (loadIssue),
        .storeReady    (storeReady),
        .storeIssue    (storeIssue)
    );

    initial Clk = 1'b0;
    always #5 Clk = ~Clk;

    function automatic dispatchLane_t makeLane(input logic st, input logic [RobPtrW-1:0] rob,
                                               input logic rdy, input logic [PhysTagW-1:0] tag);
        dispatchLane_t l;
        l = '0;
        l.valid          = 1'b1;
        l.uop.microOp    = st ? 8'h23 : 8'h03;
        l.uop.isStore    = st;
        l.uop.immUsed    = 1'b1;
        l.uop.imm        = ImmW'(rob) << 2;
        l.uop.dstUsed    = !st;
        l.uop.dstTag     = rob ^ 7'h55;
        l.uop.src1       = '{used: 1'b1, ready: rdy, tag: tag};
        l.uop.src2       = '{used: st, ready: 1'b1, tag: 7'h7f};  // store data
        l.uop.robPtr     = rob;
        return l;
    endfunction

    function automatic dispatchLane_t ld(input logic [RobPtrW-1:0] rob);
        return makeLane(1'b0, rob, 1'b1, '0);
    endfunction

    function automatic dispatchLane_t st(input logic [RobPtrW-1:0] rob);
        return makeLane(1'b1, rob, 1'b1, '0);
    endfunction

    function automatic dispatchLane_t ldWait(input logic [RobPtrW-1:0] rob,
                                             input logic [PhysTagW-1:0] tag);
        return makeLane(1'b0, rob, 1'b0, tag);
    endfunction

    function automatic dispatchLane_t idle();
        return '0;
    endfunction

    function automatic wakeDrive_t wake(input logic [1:0] port, input logic [PhysTagW-1:0] tag);
        return '{valid: 1'b1, port: port, tag: tag};
    endfunction

    function automatic wakeDrive_t noWake();
        return '0;
    endfunction

    function automatic expIssue_t issue(input logic [RobPtrW-1:0] rob);
        return '{valid: 1'b1, robPtr: rob};
    endfunction

    function automatic expIssue_t quiet();
        return '0;
    endfunction

    task automatic addRow(input int id, input dispatchLane_t a, input dispatchLane_t b,
                          input wakeDrive_t w, input logic [3:0] c, input logic dr,
                          input expIssue_t el, input expIssue_t es);
        rows.push_back('{testId: 3'(id), lane0: a, lane1: b, wk: w, ctl: c, expDr: dr,
                         expLd: el, expSt: es});
    endtask

    task automatic loadTable();
        `include "memIqTable.svh"
    endtask

    task automatic applyRow(input row_t r);
        dispatchIn[0] = r.lane0;
        dispatchIn[1] = r.lane1;
        for (int p = 0; p < WakeupPorts; p++) begin
            wakeup[p] = '0;
        end
        if (r.wk.valid) begin
            wakeup[r.wk.port] = '{valid: 1'b1, tag: r.wk.tag};
        end
        {loadReady, storeReady, stop, flush} = r.ctl;
    endtask

    task automatic checkBit(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0b got %0b", $time, name, exp, got);
        end
    endtask

    task automatic checkIssue(input string name, input expIssue_t exp, input issuePort_t got);
        checks++;
        if (got.valid !== exp.valid) begin
            errors++;
            $display("** Error at %0t: %s.valid expected %0b got %0b",
                     $time, name, exp.valid, got.valid);
        end else if (exp.valid && got.uop.robPtr !== exp.robPtr) begin
            errors++;
            $display("** Error at %0t: %s.robPtr expected %h got %h",
                     $time, name, exp.robPtr, got.uop.robPtr);
        end
    endtask

    initial begin
        rstN = 1'b0;
        applyRow('0);  // all inputs idle
        loadTable();
        tableReady = 1'b1;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge Clk);
            applyRow(rows[i]);
            #4;  // just ahead of the rising edge
            checkBit("dispatchReady", rows[i].expDr, dispatchReady);
            checkIssue("loadIssue", rows[i].expLd, loadIssue);
            checkIssue("storeIssue", rows[i].expSt, storeIssue);
            if (i == rows.size() - 1 || rows[i + 1].testId != rows[i].testId) begin
                $display("test %0d %-14s %s, %0d errors", rows[i].testId,
                         testNames[rows[i].testId - 1],
                         (errors == testStartErr) ? "ok" : "mismatch", errors - testStartErr);
                testStartErr = errors;
            end
        end
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // one cycle per row plus slack for reset
    initial begin
        wait (tableReady);
        #(rows.size() * 10 + 200);
        $display("watchdog expired before the table run finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
